// ==== Bender.yml ====
package:
  name: soc_lite

sources:
  - include_dirs:
      - hw
    files:
      - hw/soc_pkg.sv
      - hw/bus_router.sv
      - hw/dev_table.sv
      - hw/gpio_port.sv
      - hw/reset_seq.sv
      - hw/activity_led.sv
      - hw/soc_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/tb_soc.sv

// ==== hw/activity_led.sv ====
// ------------------------------
// Activity pulse with hold-off
// ------------------------------
`timescale 1ns/1ns
`include "soc_consts.svh"

module activity_led (
	input  logic clk100mhz,
	input  logic rst_p,
	input  logic access_i,
	output logic activity_o
);

	logic [`SOC_ACT_CNTR_W-1:0] cntr_q;

	// Accesses during the hold-off are dropped
	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			cntr_q     <= '0;
			activity_o <= 1'b0;
		end else if (cntr_q != '0) begin
			cntr_q     <= cntr_q - 1'b1;
			activity_o <= 1'b0;
		end else if (access_i) begin
			cntr_q     <= '1;
			activity_o <= 1'b1;
		end
	end

endmodule

// ==== hw/bus_router.sv ====
// ------------------------------
// Slot decode and response return
// ------------------------------
`timescale 1ns/1ns
`include "soc_consts.svh"

module bus_router (
	input  logic                   clk100mhz,
	input  logic                   sys_rst_i,
	input  logic                   req_valid_i,
	input  soc_pkg::bus_req_t      req_i,
	input  logic [`SOC_DATA_W-1:0] devtbl_rdata_i,
	input  logic [`SOC_DATA_W-1:0] gpio_rdata_i,
	output logic                   req_ready_o,
	output logic                   devtbl_valid_o,
	output logic                   gpio_valid_o,
	output logic                   rsp_valid_o,
	output logic [`SOC_DATA_W-1:0] rsp_data_o,
	output logic                   access_o
);
	import soc_pkg::*;

	logic [`SOC_SLOT_W-1:0] slot;
	logic [`SOC_SLOT_W-1:0] rsp_slot_q;
	logic                   rsp_rd_q;
	logic                   accept;

	assign slot        = req_i.addr[`SOC_ADDR_W-1:`SOC_OFFS_W];
	assign req_ready_o = !sys_rst_i;
	assign accept      = req_valid_i && req_ready_o;

	assign devtbl_valid_o = accept && (slot == `SOC_SLOT_DEVTBL);
	assign gpio_valid_o   = accept && (slot == `SOC_SLOT_GPIO);
	assign access_o       = accept;

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			rsp_valid_o <= 1'b0;
			rsp_rd_q    <= 1'b0;
		end else begin
			rsp_valid_o <= accept;
			if (accept)
				rsp_rd_q <= (req_i.op == BUS_RD);
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (accept)
			rsp_slot_q <= slot;
	end

	// Invalid slots and writes answer with zero
	always_comb begin
		rsp_data_o = '0;
		if (rsp_rd_q) begin
			case (rsp_slot_q)
				`SOC_SLOT_DEVTBL: rsp_data_o = devtbl_rdata_i;
				`SOC_SLOT_GPIO:   rsp_data_o = gpio_rdata_i;
				default:          rsp_data_o = '0;
			endcase
		end
	end

	a_strobe_onehot: assert property (@(posedge clk100mhz)
		(devtbl_valid_o || gpio_valid_o) |->
			(req_ready_o && !(devtbl_valid_o && gpio_valid_o)));

endmodule

// ==== hw/dev_table.sv ====
// ------------------------------
// Device table slave, also decodes software reset commands
// ------------------------------
`timescale 1ns/1ns
`include "soc_consts.svh"

module dev_table (
	input  logic                   clk100mhz,
	input  logic                   sys_rst_i,
	input  logic                   valid_i,
	input  soc_pkg::bus_req_t      req_i,
	output logic [`SOC_DATA_W-1:0] rdata_o,
	output soc_pkg::sw_rst_t       sw_rst_o
);
	import soc_pkg::*;

	localparam logic [`SOC_DATA_W-2:0] MAPSZ = `SOC_MAPSZ_WORDS;

	logic [`SOC_OFFS_W-1:0] offs;
	logic [`SOC_OFFS_W-2:0] entry;
	logic [`SOC_DATA_W-1:0] id_word;
	logic [`SOC_DATA_W-1:0] rd_word;
	logic                   use_intr;
	sw_rst_t                sw_cmd;

	// Two words per entry, identifier then map size
	assign offs  = req_i.addr[`SOC_OFFS_W-1:0];
	assign entry = offs[`SOC_OFFS_W-1:1];

	always_comb begin
		id_word  = `SOC_ID_INVALID;
		use_intr = 1'b0;
		case (entry)
			`SOC_SLOT_DEVTBL: id_word = `SOC_ID_DEVTBL;
			`SOC_SLOT_GPIO: begin
				id_word  = `SOC_ID_GPIO;
				use_intr = 1'b1;
			end
			default: id_word = `SOC_ID_INVALID;
		endcase
		if (entry >= `SOC_DEV_COUNT)
			rd_word = '0;
		else if (offs[0])
			rd_word = {use_intr, MAPSZ};
		else
			rd_word = id_word;
	end

	// Command word at offset 0, 2'b10 warm, 2'b01 power-off
	always_comb begin
		sw_cmd = '0;
		if (valid_i && req_i.op == BUS_WR && offs == '0) begin
			case (req_i.wdata[1:0])
				2'b10:   sw_cmd.warm   = 1'b1;
				2'b01:   sw_cmd.pwroff = 1'b1;
				default: sw_cmd        = '0;
			endcase
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i)
			sw_rst_o <= '0;
		else
			sw_rst_o <= sw_cmd;
	end

	always_ff @(posedge clk100mhz) begin
		if (valid_i)
			rdata_o <= rd_word;
	end

	a_cmd_exclusive: assert property (@(posedge clk100mhz)
		!(sw_rst_o.warm && sw_rst_o.pwroff));

endmodule

// ==== hw/gpio_port.sv ====
// ------------------------------
// GPIO slave with change interrupt
// ------------------------------
`timescale 1ns/1ns
`include "soc_consts.svh"

module gpio_port (
	input  logic                       clk100mhz,
	input  logic                       sys_rst_i,
	input  logic                       valid_i,
	input  soc_pkg::bus_req_t          req_i,
	input  logic [`SOC_GPIO_COUNT-1:0] gp_i,
	output logic [`SOC_DATA_W-1:0]     rdata_o,
	output logic [`SOC_GPIO_COUNT-1:0] gp_o,
	output logic                       irq_o
);
	import soc_pkg::*;

	localparam int PAD_W = `SOC_DATA_W - `SOC_GPIO_COUNT;

	logic [`SOC_GPIO_COUNT-1:0] gp_in_q;
	logic [`SOC_GPIO_COUNT-1:0] gp_prev_q;
	logic [`SOC_OFFS_W-1:0]     offs;
	logic                       wr;

	assign offs = req_i.addr[`SOC_OFFS_W-1:0];
	assign wr   = valid_i && (req_i.op == BUS_WR);

	always_ff @(posedge clk100mhz) begin
		gp_in_q   <= gp_i;
		gp_prev_q <= gp_in_q;
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			gp_o  <= '0;
			irq_o <= 1'b0;
		end else begin
			if (wr && offs == 'd0)
				gp_o <= req_i.wdata[`SOC_GPIO_COUNT-1:0];
			if (wr && offs == 'd2)
				irq_o <= 1'b0;
			// A change in the same cycle wins over the clear
			if (gp_in_q != gp_prev_q)
				irq_o <= 1'b1;
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (valid_i) begin
			case (offs)
				'd0:     rdata_o <= {{PAD_W{1'b0}}, gp_in_q};
				'd1:     rdata_o <= {{PAD_W{1'b0}}, gp_o};
				'd2:     rdata_o <= {{(`SOC_DATA_W-1){1'b0}}, irq_o};
				default: rdata_o <= '0;
			endcase
		end
	end

endmodule

// ==== hw/reset_seq.sv ====
// ------------------------------
// System reset counter and power-off latch
// ------------------------------
`timescale 1ns/1ns
`include "soc_consts.svh"

module reset_seq (
	input  logic             clk100mhz,
	input  logic             rst_p,
	input  soc_pkg::sw_rst_t sw_rst_i,
	output logic             sys_rst_o
);

	logic [`SOC_RST_CNTR_W-1:0] cntr_q;
	logic                       pwroff_q;

	always_ff @(posedge clk100mhz) begin
		if (rst_p || sw_rst_i.warm)
			cntr_q <= '1;
		else if (cntr_q != '0)
			cntr_q <= cntr_q - 1'b1;
	end

	// Only the external reset releases a power-off
	always_ff @(posedge clk100mhz) begin
		if (rst_p)
			pwroff_q <= 1'b0;
		else if (sw_rst_i.pwroff)
			pwroff_q <= 1'b1;
	end

	assign sys_rst_o = (cntr_q != '0) || pwroff_q;

	a_pwroff_holds: assert property (@(posedge clk100mhz)
		(pwroff_q && !rst_p) |=> (pwroff_q && sys_rst_o));

endmodule

// ==== hw/soc_consts.svh ====
// ------------------------------
// Widths, slot map and device-table contents
// Included by the RTL and the testbench
// ------------------------------
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Bus geometry
`define SOC_DATA_W 32
`define SOC_ADDR_W 12
`define SOC_SLOT_W 4
`define SOC_OFFS_W 8

// Slot numbers, all others are the invalid device
`define SOC_SLOT_DEVTBL 0
`define SOC_SLOT_GPIO   1

// Device table
`define SOC_DEV_COUNT   3
`define SOC_ID_DEVTBL   7
`define SOC_ID_GPIO     6
`define SOC_ID_INVALID  0
`define SOC_MAPSZ_WORDS 256

`define SOC_GPIO_COUNT 8

// Counter sizes
`define SOC_RST_CNTR_W 4
`define SOC_ACT_CNTR_W 7

`endif

// ==== hw/soc_pkg.sv ====
// ------------------------------
// Bus request and reset command types
// ------------------------------
`include "soc_consts.svh"

package soc_pkg;

	// Op encoding of the PI1 bus
	typedef enum logic [1:0] {
		BUS_WR = 2'b01,
		BUS_RD = 2'b10
	} bus_op_e;

	typedef struct packed {
		bus_op_e                 op;
		logic [`SOC_ADDR_W-1:0] addr;
		logic [`SOC_DATA_W-1:0] wdata;
	} bus_req_t;

	// One-cycle commands from the device table
	typedef struct packed {
		logic warm;
		logic pwroff;
	} sw_rst_t;

endpackage

// ==== hw/soc_top.sv ====
// ------------------------------
// Top level, external master port plus GPIO pins
// ------------------------------
`timescale 1ns/1ns
`include "soc_consts.svh"

module soc_top (
	input  logic                       clk100mhz,
	input  logic                       rst_p,
	input  logic                       req_valid_i,
	input  soc_pkg::bus_req_t          req_i,
	input  logic [`SOC_GPIO_COUNT-1:0] gp_i,
	output logic                       req_ready_o,
	output logic                       rsp_valid_o,
	output logic [`SOC_DATA_W-1:0]     rsp_data_o,
	output logic [`SOC_GPIO_COUNT-1:1] gp_o,
	output logic                       irq_o,
	output logic                       activity_o
);
	import soc_pkg::*;

	logic                       sys_rst;
	sw_rst_t                    sw_rst;
	logic                       devtbl_valid;
	logic                       gpio_valid;
	logic [`SOC_DATA_W-1:0]     devtbl_rdata;
	logic [`SOC_DATA_W-1:0]     gpio_rdata;
	logic [`SOC_GPIO_COUNT-1:0] gp_out;
	logic                       access;

	// Bit 0 is not pinned out
	assign gp_o = gp_out[`SOC_GPIO_COUNT-1:1];

	reset_seq reset_seq_inst (
		.clk100mhz (clk100mhz),
		.rst_p     (rst_p),
		.sw_rst_i  (sw_rst),
		.sys_rst_o (sys_rst)
	);

	bus_router bus_router_inst (
		.clk100mhz      (clk100mhz),
		.sys_rst_i      (sys_rst),
		.req_valid_i    (req_valid_i),
		.req_i          (req_i),
		.devtbl_rdata_i (devtbl_rdata),
		.gpio_rdata_i   (gpio_rdata),
		.req_ready_o    (req_ready_o),
		.devtbl_valid_o (devtbl_valid),
		.gpio_valid_o   (gpio_valid),
		.rsp_valid_o    (rsp_valid_o),
		.rsp_data_o     (rsp_data_o),
		.access_o       (access)
	);

	dev_table dev_table_inst (
		.clk100mhz (clk100mhz),
		.sys_rst_i (sys_rst),
		.valid_i   (devtbl_valid),
		.req_i     (req_i),
		.rdata_o   (devtbl_rdata),
		.sw_rst_o  (sw_rst)
	);

	gpio_port gpio_port_inst (
		.clk100mhz (clk100mhz),
		.sys_rst_i (sys_rst),
		.valid_i   (gpio_valid),
		.req_i     (req_i),
		.gp_i      (gp_i),
		.rdata_o   (gpio_rdata),
		.gp_o      (gp_out),
		.irq_o     (irq_o)
	);

	activity_led activity_led_inst (
		.clk100mhz  (clk100mhz),
		.rst_p      (rst_p),
		.access_i   (access),
		.activity_o (activity_o)
	);

endmodule

// ==== sim/soc_testdata.txt ====
# act addr wdata gp_i exp, all hex; rd/wr exp is the response word, rdy addr is a cycle limit
# wait exp is {ready_low[12], activity pulses[11:8] (f skips), gp_o[7:1], irq[0]}, rst addr is cycles
rdy  010 00000000 00 0000000f
rd   000 00000000 00 00000007
rd   001 00000000 00 00000100
rd   002 00000000 00 00000006
rd   003 00000000 00 80000100
rd   004 00000000 00 00000000
rd   005 00000000 00 00000100
rd   006 00000000 00 00000000
rd   2a0 00000000 00 00000000
wr   100 000000a5 00 00000000
rd   101 00000000 00 000000a5
wait 003 00000000 5a 00000fa5
rd   100 00000000 5a 0000005a
rd   102 00000000 5a 00000001
wr   102 00000000 5a 00000000
rd   102 00000000 5a 00000000
wr   000 00000003 5a 00000000
wait 003 00000000 3c 00000fa5
wr   000 00000002 3c 00000000
wait 002 00000000 3c 00001f00
rdy  010 00000000 3c 0000000e
rd   101 00000000 3c 00000000
rd   102 00000000 3c 00000000
wr   000 00000001 3c 00000000
wait 028 00000000 3c 00001f00
rst  010 00000000 3c 00000000
rdy  010 00000000 3c 0000000f
wait 0a0 00000000 3c 00000000
rd   000 00000000 3c 00000007
rd   101 00000000 3c 00000000
wr   100 00000003 3c 00000000
rd   101 00000000 3c 00000003
wait 050 00000000 3c 00000102
rd   000 00000000 3c 00000007
wait 0a0 00000000 3c 00000002
rd   001 00000000 3c 00000100
wait 004 00000000 3c 00000102

// ==== sim/tb_soc.sv ====
// ------------------------------
// Testbench for soc_top driven by sim/soc_testdata.txt
// Run from the project root
// ------------------------------
`timescale 1ns/1ns
`include "soc_consts.svh"

module tb_soc;
	import soc_pkg::*;

	localparam int CLK_HALF    = 5;
	localparam int RST_CYCLES  = 16;
	localparam int LINE_BUDGET = 200;
	localparam int HOLD_OFF    = (1 << `SOC_ACT_CNTR_W) - 1;

	logic                       clk100mhz;
	logic                       rst_p;
	logic                       req_valid_i;
	bus_req_t                   req_i;
	logic [`SOC_GPIO_COUNT-1:0] gp_i;
	logic                       req_ready_o;
	logic                       rsp_valid_o;
	logic [`SOC_DATA_W-1:0]     rsp_data_o;
	logic [`SOC_GPIO_COUNT-1:1] gp_o;
	logic                       irq_o;
	logic                       activity_o;

	integer seed;
	integer fd;
	integer n_lines;
	integer act_pulses;
	integer cyc;
	integer last_pulse;
	logic   have_pulse;

	soc_top soc_top_inst (
		.clk100mhz   (clk100mhz),
		.rst_p       (rst_p),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.gp_i        (gp_i),
		.req_ready_o (req_ready_o),
		.rsp_valid_o (rsp_valid_o),
		.rsp_data_o  (rsp_data_o),
		.gp_o        (gp_o),
		.irq_o       (irq_o),
		.activity_o  (activity_o)
	);

	always #CLK_HALF clk100mhz = ~clk100mhz;

	task automatic end_with_failure();
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			$display("Mismatch at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
			end_with_failure();
		end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic tick();
		@(posedge clk100mhz);
		#1;
	endtask

	task automatic idle_tick();
		tick();
		check_value("rsp_valid_o", 0, rsp_valid_o);
	endtask

	task automatic do_request(input bus_op_e op, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [31:0] exp);
		integer gap;
		logic   ready_seen;
		gap = {$random(seed)} % 4;
		repeat (gap)
			idle_tick();
		req_valid_i = 1'b1;
		req_i.op    = op;
		req_i.addr  = addr[`SOC_ADDR_W-1:0];
		req_i.wdata = wdata;
		ready_seen  = 1'b0;
		// Accepted on the first edge that sees ready high
		while (!ready_seen) begin
			ready_seen = (req_ready_o === 1'b1);
			tick();
		end
		req_valid_i = 1'b0;
		check_value("rsp_valid_o", 1, rsp_valid_o);
		check_value("rsp_data_o", exp, rsp_data_o);
	endtask

	task automatic wait_for_ready(input integer limit, input logic [31:0] exp);
		integer n;
		n = 0;
		while (req_ready_o !== 1'b1 && n < limit) begin
			idle_tick();
			n = n + 1;
		end
		assert (req_ready_o === 1'b1) else begin
			$display("req_ready_o did not rise within %0d cycles", limit);
			end_with_failure();
		end
		check_value("req_ready_o rise cycle", exp, n);
	endtask

	// exp holds ready-low flag, activity count, gp_o and irq_o
	task automatic wait_cycles(input integer n, input logic [31:0] exp);
		repeat (n) begin
			idle_tick();
			if (exp[12])
				check_value("req_ready_o", 0, req_ready_o);
		end
		check_value("gp_o", {25'd0, exp[7:1]}, {25'd0, gp_o});
		check_value("irq_o", {31'd0, exp[0]}, {31'd0, irq_o});
		if (exp[11:8] != 4'hf)
			check_value("activity_o pulses", {28'd0, exp[11:8]}, act_pulses);
		act_pulses = 0;
	endtask

	task automatic pulse_reset(input integer n);
		rst_p = 1'b1;
		repeat (n)
			idle_tick();
		rst_p = 1'b0;
	endtask

	// Counts activity pulses and checks the hold-off between them
	always @(negedge clk100mhz) begin
		cyc = cyc + 1;
		if (rst_p === 1'b1) begin
			have_pulse = 1'b0;
		end else if (activity_o === 1'b1) begin
			act_pulses = act_pulses + 1;
			assert (!have_pulse || cyc - last_pulse > HOLD_OFF) else begin
				$display("activity_o pulsed again %0d cycles after the previous pulse",
					cyc - last_pulse);
				end_with_failure();
			end
			have_pulse = 1'b1;
			last_pulse = cyc;
		end
	end

	initial begin
		@(negedge rst_p);
		repeat (n_lines * LINE_BUDGET)
			@(posedge clk100mhz);
		$display("Timeout: test data not finished after %0d cycles", n_lines * LINE_BUDGET);
		end_with_failure();
	end

	initial begin
		logic [63:0]      tok;
		logic [8*128-1:0] text;
		logic [31:0]      f_addr;
		logic [31:0]      f_wdata;
		logic [31:0]      f_gp;
		logic [31:0]      f_exp;
		integer           code;
		clk100mhz   = 1'b0;
		rst_p       = 1'b1;
		req_valid_i = 1'b0;
		req_i.op    = BUS_RD;
		req_i.addr  = '0;
		req_i.wdata = '0;
		gp_i        = '0;
		seed        = 45;
		act_pulses  = 0;
		cyc         = 0;
		last_pulse  = 0;
		have_pulse  = 1'b0;
		n_lines     = 0;

		fd = $fopen("sim/soc_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open sim/soc_testdata.txt");
			end_with_failure();
		end
		while ($fgets(text, fd) != 0)
			n_lines = n_lines + 1;
		$fclose(fd);
		fd = $fopen("sim/soc_testdata.txt", "r");

		repeat (RST_CYCLES)
			tick();
		rst_p = 1'b0;

		code = $fscanf(fd, "%s", tok);
		while (code == 1) begin
			if (tok == "#") begin
				code = $fgets(text, fd);
			end else begin
				code = $fscanf(fd, "%h %h %h %h", f_addr, f_wdata, f_gp, f_exp);
				if (code != 4) begin
					$display("Malformed line in test data");
					end_with_failure();
				end
				gp_i = f_gp[`SOC_GPIO_COUNT-1:0];
				case (tok)
					"rd":    do_request(BUS_RD, f_addr, '0, f_exp);
					"wr":    do_request(BUS_WR, f_addr, f_wdata, f_exp);
					"rdy":   wait_for_ready(f_addr, f_exp);
					"wait":  wait_cycles(f_addr, f_exp);
					"rst":   pulse_reset(f_addr);
					default: begin
						$display("Unknown action in test data");
						end_with_failure();
					end
				endcase
			end
			code = $fscanf(fd, "%s", tok);
		end
		$fclose(fd);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+hw
hw/soc_pkg.sv
hw/bus_router.sv
hw/dev_table.sv
hw/gpio_port.sv
hw/reset_seq.sv
hw/activity_led.sv
hw/soc_top.sv
sim/tb_soc.sv
